/* main_bus.f */
common/board_pkg.sv
memory/dual_ram16.sv
source/addr_decode.sv
source/vdp_strobes.sv
source/io_ports.sv
source/read_mux.sv
source/main_bus.sv
tb/main_bus_tb.sv

/* Makefile */
# Verilator build and run for the main_bus testbench

VERILATOR ?= verilator
TOP       ?= main_bus_tb
FILELIST  ?= main_bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F -- '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/main_bus_tb.sv */
// cpu bus model for main_bus; runs a table of read and write cycles against rom and vdp responders
module main_bus_tb;

    // one cpu bus cycle and what it should give back
    typedef struct packed {
        logic        rw;
        logic [23:0] addr;
        logic [15:0] data;
        logic [1:0]  lanes;
        logic [15:0] exp_word;
        logic        chk;
        logic [5:0]  ops;
    } cycle_t;

    // strobe bits in vdp_ops_t field order
    localparam logic [5:0] OP_NONE = 6'b000000;
    localparam logic [5:0] OP_PTR  = 6'b000001;
    localparam logic [5:0] OP_RDL  = 6'b000010;
    localparam logic [5:0] OP_RDH  = 6'b000100;
    localparam logic [5:0] OP_WRAM = 6'b001000;
    localparam logic [5:0] OP_WREG = 6'b010000;
    localparam logic [5:0] OP_SEL  = 6'b100000;

    logic                         CLK96;
    logic                         RESET96;
    board_pkg::cpu_bus_t          bus;
    logic [15:0]                  cpu_dout;
    logic [15:0]                  cpu_din;
    logic                         prg_cs;
    logic [18:0]                  prg_addr;
    logic [15:0]                  prg_data;
    logic                         prg_ok = 1'b0;
    board_pkg::vdp_ops_t          vdp_ops;
    logic [15:0]                  vdp_dout;
    logic                         vdp_ack = 1'b0;
    logic [board_pkg::PAL_AW-1:0] pal_addr;
    logic [15:0]                  pal_data;
    board_pkg::cabinet_t          cabinet;
    logic [7:0]                   dipsw_a;
    logic [7:0]                   dipsw_b;
    logic [7:0]                   dipsw_c;
    logic                         oki_bank;
    logic                         bus_busy;

    cycle_t      steps[$];
    logic [31:0] rnd;
    logic        oki_model;
    int          rom_wait = 0;
    int          cycles = 0;
    int          limit = 0;
    int          checks = 0;
    int          errors = 0;

    main_bus #(.WRAM_AW(board_pkg::WRAM_AW), .PAL_AW(board_pkg::PAL_AW)) dut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rom contents, every address bit folded in
    function automatic logic [15:0] rom_word(input logic [18:0] a);
        return {a[7:0], a[15:8]} ^ {a[18:16], 13'h1357};
    endfunction

    // joystick to active high, directions reordered
    function automatic logic [7:0] player_byte(input logic [9:0] j);
        return {2'b00, ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    function automatic logic [7:0] system_byte(input board_pkg::cabinet_t c);
        return {1'b0, ~c.start[1], ~c.start[0], ~c.coin[1], ~c.coin[0],
                ~c.test, 1'b0, ~c.service};
    endfunction

    task automatic add_read(input logic [23:0] a, input logic [15:0] e, input logic [5:0] ops);
        steps.push_back({1'b1, a, 16'h0000, 2'b11, e, 1'b1, ops});
    endtask

    // lanes are {uds_n, lds_n}
    task automatic add_write(input logic [23:0] a, input logic [15:0] d, input logic [1:0] lanes,
                             input logic [5:0] ops);
        steps.push_back({1'b0, a, d, lanes, 16'h0000, 1'b0, ops});
    endtask

    task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    // palette video side, data one edge after the address
    task automatic check_video_port(input logic [board_pkg::PAL_AW-1:0] a, input logic [15:0] e);
        @(posedge CLK96);
        pal_addr <= a;
        @(posedge CLK96);
        @(negedge CLK96);
        checks++;
        if (pal_data != e) report_err("pal_data", 32'(pal_data), 32'(e));
    endtask

    task automatic build_steps();
        logic [11:0] hi;
        logic [23:0] vdp;
        hi  = board_pkg::IO_HIGH;
        vdp = {board_pkg::VDP_PAGE, 20'h00000};
        // work ram, full words then single lanes over them
        add_write(24'h100010, 16'h1234, 2'b00, OP_NONE);
        add_write(24'h100012, 16'hBEEF, 2'b00, OP_NONE);
        add_read(24'h100010, 16'h1234, OP_NONE);
        add_write(24'h100010, 16'hAB99, 2'b01, OP_NONE);
        add_write(24'h100012, 16'h7755, 2'b10, OP_NONE);
        add_read(24'h100010, 16'hAB34, OP_NONE);
        add_read(24'h100012, 16'hBE55, OP_NONE);
        add_write(24'h10FFFE, 16'hC0DE, 2'b00, OP_NONE);
        add_read(24'h10FFFE, 16'hC0DE, OP_NONE);
        // palette, lower lane only on the second word
        add_write(24'h400020, 16'h0F3C, 2'b00, OP_NONE);
        add_write(24'h400022, 16'h7E11, 2'b00, OP_NONE);
        add_write(24'h400022, 16'hFF00, 2'b10, OP_NONE);
        add_write(24'h400FFE, 16'h5AA5, 2'b00, OP_NONE);
        add_read(24'h400020, 16'h0F3C, OP_NONE);
        add_read(24'h400022, 16'h7E00, OP_NONE);
        // program rom, both ends and one in between
        add_read(24'h000000, rom_word(19'h00000), OP_NONE);
        add_read(24'h012346, rom_word(19'h091A3), OP_NONE);
        add_read(24'h07FFFE, rom_word(19'h3FFFF), OP_NONE);
        // cabinet ports
        add_read({hi, board_pkg::IO_JUMPER}, {2{dipsw_c}}, OP_NONE);
        add_read({hi, board_pkg::IO_DSWA}, {2{dipsw_a}}, OP_NONE);
        add_read({hi, board_pkg::IO_DSWB}, {2{dipsw_b}}, OP_NONE);
        add_read({hi, board_pkg::IO_P1}, {2{player_byte(cabinet.joy1)}}, OP_NONE);
        add_read({hi, board_pkg::IO_P2}, {2{player_byte(cabinet.joy2)}}, OP_NONE);
        add_read({hi, board_pkg::IO_SYS}, {dipsw_c, system_byte(cabinet)}, OP_NONE);
        add_read({hi, 12'h020}, 16'h0000, OP_NONE);
        add_read(24'h200000, 16'h0000, OP_NONE);
        // sample bank latch, bit 4 only
        add_write({hi, board_pkg::IO_OKI_BANK}, 16'h0010, 2'b10, OP_NONE);
        add_write({hi, board_pkg::IO_OKI_BANK}, 16'hFFEF, 2'b10, OP_NONE);
        add_write({hi, board_pkg::IO_OKI_BANK}, 16'h0030, 2'b10, OP_NONE);
        add_read({hi, board_pkg::IO_OKI_BANK}, 16'h0000, OP_NONE);
        // vdp, one strobe per offset and direction
        add_write(vdp | 24'(board_pkg::VDP_PTR), 16'h0100, 2'b00, OP_PTR);
        add_read(vdp | 24'(board_pkg::VDP_RAM_H), vdp_dout, OP_RDH);
        add_read(vdp | 24'(board_pkg::VDP_RAM_L), vdp_dout, OP_RDL);
        add_write(vdp | 24'(board_pkg::VDP_SELECT), 16'h0007, 2'b00, OP_SEL);
        add_write(vdp | 24'(board_pkg::VDP_REG), 16'h00A5, 2'b00, OP_WREG);
        add_write(vdp | 24'(board_pkg::VDP_RAM_H), 16'h1357, 2'b00, OP_WRAM);
        add_write(vdp | 24'(board_pkg::VDP_RAM_L), 16'h2468, 2'b00, OP_WRAM);
        add_read(vdp | 24'(board_pkg::VDP_PTR), vdp_dout, OP_NONE);
    endtask

    // rom holds prg_ok low for the first two edges of an access
    assign prg_data = rom_word(prg_addr);

    always @(posedge CLK96) begin
        if (prg_cs) begin
            rom_wait <= rom_wait + 1;
            if (rom_wait >= 1) prg_ok <= 1'b1;
        end else begin
            rom_wait <= 0;
            prg_ok   <= 1'b0;
        end
    end

    // vdp acks one edge after any strobe
    always @(posedge CLK96) begin
        vdp_ack <= (vdp_ops != '0);
    end

    always @(posedge CLK96) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run went past %0d cycles without finishing", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        cycle_t r;
        logic   is_rom;
        logic   is_vdp;
        RESET96  = 1'b1;
        bus      = '{as_n: 1'b1, rw: 1'b1, uds_n: 1'b1, lds_n: 1'b1, addr: '0};
        cpu_dout = 16'h0000;
        pal_addr = '0;
        rnd      = xorshift32(32'h2e99_a2b5);
        cabinet  = rnd[29:0];
        rnd      = xorshift32(rnd);
        dipsw_a  = rnd[7:0];
        dipsw_b  = rnd[15:8];
        dipsw_c  = rnd[23:16];
        rnd      = xorshift32(rnd);
        vdp_dout = rnd[15:0];
        oki_model = 1'b0;
        build_steps();
        limit = steps.size() * 6 + 200;
        repeat (16) @(posedge CLK96);
        RESET96 <= 1'b0;

        foreach (steps[i]) begin
            r      = steps[i];
            is_rom = (r.addr <= board_pkg::ROM_LIMIT);
            is_vdp = (r.addr[23:20] == board_pkg::VDP_PAGE);
            if (!r.rw && r.addr == {board_pkg::IO_HIGH, board_pkg::IO_OKI_BANK}) begin
                oki_model = r.data[4];
            end
            @(posedge CLK96);
            bus.as_n  <= 1'b0;
            bus.rw    <= r.rw;
            bus.uds_n <= r.lanes[1];
            bus.lds_n <= r.lanes[0];
            bus.addr  <= r.addr[23:1];
            cpu_dout  <= r.data;
            // previous strobe acked and gone, bus idle
            @(negedge CLK96);
            checks += 2;
            if (vdp_ops != '0) report_err("vdp_ops", 32'(vdp_ops), 32'(0));
            if (bus_busy) report_err("bus_busy", 32'(bus_busy), 32'(0));
            // selects live, slow devices still owe an answer
            @(posedge CLK96);
            @(negedge CLK96);
            if (is_rom) begin
                checks += 3;
                if (!prg_cs) report_err("prg_cs", 32'(prg_cs), 32'(1));
                if (prg_addr != r.addr[19:1]) report_err("prg_addr", 32'(prg_addr), 32'(r.addr[19:1]));
                if (!bus_busy) report_err("bus_busy", 32'(bus_busy), 32'(1));
            end
            if (is_vdp) begin
                checks++;
                if (!bus_busy) report_err("bus_busy", 32'(bus_busy), 32'(1));
            end
            repeat (2) @(posedge CLK96);
            @(negedge CLK96);
            checks += 2;
            if (r.chk && cpu_din != r.exp_word) report_err("cpu_din", 32'(cpu_din), 32'(r.exp_word));
            if (vdp_ops != r.ops) report_err("vdp_ops", 32'(vdp_ops), 32'(r.ops));
            checks++;
            if (oki_bank != oki_model) report_err("oki_bank", 32'(oki_bank), 32'(oki_model));
            if (is_rom) begin
                checks++;
                if (bus_busy) report_err("bus_busy", 32'(bus_busy), 32'(0));
            end
            // end of cycle, rw held like a real 68000
            @(posedge CLK96);
            bus.as_n  <= 1'b1;
            bus.uds_n <= 1'b1;
            bus.lds_n <= 1'b1;
            @(posedge CLK96);
        end

        check_video_port(11'h010, 16'h0F3C);
        check_video_port(11'h011, 16'h7E00);
        check_video_port(11'h7FF, 16'h5AA5);

        $display("main_bus_tb done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* source/main_bus.sv */
// top level of the main cpu bus glue; wires decode, vdp strobes, i/o, read mux and both rams
module main_bus #(
    parameter int WRAM_AW = board_pkg::WRAM_AW,
    parameter int PAL_AW  = board_pkg::PAL_AW
) (
    input  logic                CLK96,
    input  logic                RESET96,
    // cpu bus
    input  board_pkg::cpu_bus_t bus,
    input  logic [15:0]         cpu_dout,
    output logic [15:0]         cpu_din,
    // program rom
    output logic                prg_cs,
    output logic [18:0]         prg_addr,
    input  logic [15:0]         prg_data,
    input  logic                prg_ok,
    // vdp
    output board_pkg::vdp_ops_t vdp_ops,
    input  logic [15:0]         vdp_dout,
    input  logic                vdp_ack,
    // palette, video side
    input  logic [PAL_AW-1:0]   pal_addr,
    output logic [15:0]         pal_data,
    // cabinet
    input  board_pkg::cabinet_t cabinet,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  logic [7:0]          dipsw_c,
    // sound and bus status
    output logic                oki_bank,
    output logic                bus_busy
);

    board_pkg::region_sel_t sel;
    logic [11:0]            io_offset;
    logic [15:0]            io_word;
    logic [15:0]            wram_q;
    logic [15:0]            pal_q;
    logic [1:0]             wram_we;
    logic [1:0]             pal_we;

    // rom sees a[19:1] directly
    assign prg_addr = bus.addr[19:1];

    // byte lanes, upper then lower
    assign wram_we = {sel.wram & ~bus.rw & ~bus.uds_n, sel.wram & ~bus.rw & ~bus.lds_n};
    assign pal_we  = {sel.pal & ~bus.rw & ~bus.uds_n, sel.pal & ~bus.rw & ~bus.lds_n};

    addr_decode u_decode (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .bus       (bus),
        .prg_ok    (prg_ok),
        .vdp_ack   (vdp_ack),
        .sel       (sel),
        .io_offset (io_offset),
        .prg_cs    (prg_cs),
        .bus_busy  (bus_busy)
    );

    vdp_strobes u_vdp (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .sel       (sel),
        .rw        (bus.rw),
        .io_offset (io_offset),
        .vdp_ack   (vdp_ack),
        .vdp_ops   (vdp_ops)
    );

    io_ports u_io (
        .CLK96     (CLK96),
        .RESET96   (RESET96),
        .sel       (sel),
        .rw        (bus.rw),
        .io_offset (io_offset),
        .cpu_dout  (cpu_dout),
        .cabinet   (cabinet),
        .dipsw_a   (dipsw_a),
        .dipsw_b   (dipsw_b),
        .dipsw_c   (dipsw_c),
        .io_word   (io_word),
        .oki_bank  (oki_bank)
    );

    read_mux u_mux (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .sel      (sel),
        .rw       (bus.rw),
        .prg_data (prg_data),
        .vdp_dout (vdp_dout),
        .wram_q   (wram_q),
        .pal_q    (pal_q),
        .io_word  (io_word),
        .cpu_din  (cpu_din)
    );

    // work ram, second port left idle
    dual_ram16 #(.AW(WRAM_AW)) u_wram (
        .CLK96 (CLK96),
        .data0 (cpu_dout),
        .addr0 (bus.addr[WRAM_AW:1]),
        .we0   (wram_we),
        .q0    (wram_q),
        .addr1 (bus.addr[WRAM_AW:1]),
        .q1    ()
    );

    // palette ram, second port feeds the video side
    dual_ram16 #(.AW(PAL_AW)) u_palram (
        .CLK96 (CLK96),
        .data0 (cpu_dout),
        .addr0 (bus.addr[PAL_AW:1]),
        .we0   (pal_we),
        .q0    (pal_q),
        .addr1 (pal_addr),
        .q1    (pal_data)
    );

endmodule

/* source/read_mux.sv */
// registers the word returned to the cpu from whichever region the cycle selected
module read_mux (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  board_pkg::region_sel_t sel,
    input  logic                   rw,
    input  logic [15:0]            prg_data,
    input  logic [15:0]            vdp_dout,
    input  logic [15:0]            wram_q,
    input  logic [15:0]            pal_q,
    input  logic [15:0]            io_word,
    output logic [15:0]            cpu_din
);

    logic [15:0] next_din;

    // selects are one-hot so order only matters for readability
    always_comb begin
        next_din = 16'h0000;
        if (rw) begin
            if (sel.rom) begin
                next_din = prg_data;
            end else if (sel.wram) begin
                next_din = wram_q;
            end else if (sel.vdp) begin
                next_din = vdp_dout;
            end else if (sel.pal) begin
                next_din = pal_q;
            end else if (sel.io) begin
                next_din = io_word;
            end
        end
    end

    // writes and idle cycles read back zero
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            cpu_din <= 16'h0000;
        end else begin
            cpu_din <= next_din;
        end
    end

endmodule

/* source/io_ports.sv */
// formats cabinet inputs and dip banks into i/o read words and holds the sample bank latch
module io_ports (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  board_pkg::region_sel_t sel,
    input  logic                   rw,
    input  logic [11:0]            io_offset,
    input  logic [15:0]            cpu_dout,
    input  board_pkg::cabinet_t    cabinet,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic [7:0]             dipsw_c,
    output logic [15:0]            io_word,
    output logic                   oki_bank
);

    logic [7:0] p1_byte;
    logic [7:0] p2_byte;
    logic [7:0] sys_byte;

    // board wants active high, directions reordered
    assign p1_byte = {2'b00, ~cabinet.joy1[5], ~cabinet.joy1[4],
                      ~cabinet.joy1[0], ~cabinet.joy1[1],
                      ~cabinet.joy1[2], ~cabinet.joy1[3]};
    assign p2_byte = {2'b00, ~cabinet.joy2[5], ~cabinet.joy2[4],
                      ~cabinet.joy2[0], ~cabinet.joy2[1],
                      ~cabinet.joy2[2], ~cabinet.joy2[3]};

    // start, coin, test and service share one byte
    assign sys_byte = {1'b0, ~cabinet.start[1], ~cabinet.start[0],
                       ~cabinet.coin[1], ~cabinet.coin[0],
                       ~cabinet.test, 1'b0, ~cabinet.service};

    // byte ports are mirrored on both data lanes
    always_comb begin
        case (io_offset)
            board_pkg::IO_JUMPER: io_word = {2{dipsw_c}};
            board_pkg::IO_DSWA:   io_word = {2{dipsw_a}};
            board_pkg::IO_DSWB:   io_word = {2{dipsw_b}};
            board_pkg::IO_P1:     io_word = {2{p1_byte}};
            board_pkg::IO_P2:     io_word = {2{p2_byte}};
            // third dip bank rides in the upper byte here
            board_pkg::IO_SYS:    io_word = {dipsw_c, sys_byte};
            default:              io_word = 16'h0000;
        endcase
    end

    // adpcm sample bank, only bit 4 matters
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            oki_bank <= 1'b0;
        end else if (sel.io && !rw && (io_offset == board_pkg::IO_OKI_BANK)) begin
            oki_bank <= cpu_dout[4];
        end
    end

endmodule

/* source/vdp_strobes.sv */
// turns cpu accesses to the vdp window into single held operation strobes
module vdp_strobes (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  board_pkg::region_sel_t sel,
    input  logic                   rw,
    input  logic [11:0]            io_offset,
    input  logic                   vdp_ack,
    output board_pkg::vdp_ops_t    vdp_ops
);

    board_pkg::vdp_ops_t hit;

    // offset nibble plus direction picks the operation
    always_comb begin
        hit = '0;
        if (rw) begin
            case (io_offset[3:0])
                board_pkg::VDP_RAM_H: hit.read_ram_h = 1'b1;
                board_pkg::VDP_RAM_L: hit.read_ram_l = 1'b1;
                default: hit = '0;
            endcase
        end else begin
            case (io_offset[3:0])
                board_pkg::VDP_PTR:    hit.set_ram_ptr = 1'b1;
                // both halves go through the same data port
                board_pkg::VDP_RAM_H,
                board_pkg::VDP_RAM_L:  hit.write_ram   = 1'b1;
                board_pkg::VDP_SELECT: hit.select_reg  = 1'b1;
                board_pkg::VDP_REG:    hit.write_reg   = 1'b1;
                default: hit = '0;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vdp_ops <= '0;
        end else if (sel.vdp && (hit != '0)) begin
            // new access replaces whatever was pending
            vdp_ops <= hit;
        end else if (!sel.vdp && vdp_ack) begin
            // ack only counts once the cpu has left the window
            vdp_ops <= '0;
        end
    end

    a_ops_onehot : assert property (
        @(posedge CLK96) disable iff (RESET96)
        $onehot0(vdp_ops)
    );

endmodule

/* source/addr_decode.sv */
// registers the region selects and i/o offset for each cpu bus cycle and flags slow devices
module addr_decode (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  board_pkg::cpu_bus_t    bus,
    input  logic                   prg_ok,
    input  logic                   vdp_ack,
    output board_pkg::region_sel_t sel,
    output logic [11:0]            io_offset,
    output logic                   prg_cs,
    output logic                   bus_busy
);

    board_pkg::bus_addr_u   baddr;
    board_pkg::region_sel_t hit;

    // word address back to a byte address, a0 always zero
    assign baddr = {bus.addr, 1'b0};

    always_comb begin
        hit = '0;
        // program rom, 0x000000 - 0x07ffff
        hit.rom  = {baddr.region.page, baddr.region.rest} <= board_pkg::ROM_LIMIT;
        // work ram, 0x100000 - 0x10ffff
        hit.wram = {baddr.region.page, baddr.region.rest[19:16]} == board_pkg::WRAM_PAGE;
        // vdp registers
        hit.vdp  = baddr.region.page == board_pkg::VDP_PAGE;
        // palette ram, cpu side
        hit.pal  = baddr.region.page == board_pkg::PAL_PAGE;
        // i/o window at 0x700xxx
        hit.io   = baddr.io.high == board_pkg::IO_HIGH;
    end

    // selects only live while the strobe is low
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel <= '0;
        end else if (!bus.as_n) begin
            sel <= hit;
        end else begin
            sel <= '0;
        end
    end

    // offset follows the address, decoded downstream only under sel.io or sel.vdp
    always_ff @(posedge CLK96) begin
        io_offset <= baddr.io.offset;
    end

    // rom chip select drops as soon as the cpu ends the cycle
    assign prg_cs = sel.rom & ~bus.as_n;

    // slow devices still owe data
    assign bus_busy = (sel.rom & ~prg_ok) | (sel.vdp & ~vdp_ack);

    // map regions must never overlap
    a_sel_onehot : assert property (
        @(posedge CLK96) disable iff (RESET96)
        $onehot0(sel)
    );

endmodule

/* memory/dual_ram16.sv */
// two-port 16-bit ram, byte-lane writes on port 0 and a read-only second port
module dual_ram16 #(
    parameter int AW = 10
) (
    input  logic          CLK96,
    // port 0, cpu side
    input  logic [15:0]   data0,
    input  logic [AW-1:0] addr0,
    input  logic [1:0]    we0,
    output logic [15:0]   q0,
    // port 1, read only
    input  logic [AW-1:0] addr1,
    output logic [15:0]   q1
);

    logic [15:0] mem [2**AW];

    // we0[1] upper lane, we0[0] lower lane
    always_ff @(posedge CLK96) begin
        if (we0[1]) begin
            mem[addr0][15:8] <= data0[15:8];
        end
        if (we0[0]) begin
            mem[addr0][7:0] <= data0[7:0];
        end
    end

    // registered reads, old data on a same-edge write
    always_ff @(posedge CLK96) begin
        q0 <= mem[addr0];
    end

    always_ff @(posedge CLK96) begin
        q1 <= mem[addr1];
    end

endmodule

/* common/board_pkg.sv */
// shared bus types, memory map and i/o offsets for the main cpu bus glue; referenced by scope
package board_pkg;

    // default ram depths in words, as address bits
    localparam int WRAM_AW = 15;
    localparam int PAL_AW  = 11;

    // cpu word address, a[23:1]
    typedef logic [23:1] cpu_addr_t;

    // byte address, decoded by page for regions and by high part for the i/o window
    typedef union packed {
        struct packed {
            logic [3:0]  page;
            logic [19:0] rest;
        } region;
        struct packed {
            logic [11:0] high;
            logic [11:0] offset;
        } io;
    } bus_addr_u;

    // cpu side of the bus, strobes active low
    typedef struct packed {
        logic      as_n;
        logic      rw;
        logic      uds_n;
        logic      lds_n;
        cpu_addr_t addr;
    } cpu_bus_t;

    // one region at most per bus cycle
    typedef struct packed {
        logic rom;
        logic wram;
        logic vdp;
        logic pal;
        logic io;
    } region_sel_t;

    // vdp operation strobes, held until ack
    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } vdp_ops_t;

    // cabinet controls, all active low
    typedef struct packed {
        logic [9:0] joy1;
        logic [9:0] joy2;
        logic [3:0] start;
        logic [3:0] coin;
        logic       service;
        logic       test;
    } cabinet_t;

    // memory map
    localparam logic [23:0] ROM_LIMIT = 24'h07FFFF;
    localparam logic [7:0]  WRAM_PAGE = 8'h10;
    localparam logic [3:0]  VDP_PAGE  = 4'h3;
    localparam logic [3:0]  PAL_PAGE  = 4'h4;
    localparam logic [11:0] IO_HIGH   = 12'h700;

    // i/o window byte offsets
    localparam logic [11:0] IO_JUMPER   = 12'h000;
    localparam logic [11:0] IO_DSWA     = 12'h004;
    localparam logic [11:0] IO_DSWB     = 12'h008;
    localparam logic [11:0] IO_P1       = 12'h00C;
    localparam logic [11:0] IO_P2       = 12'h010;
    localparam logic [11:0] IO_SYS      = 12'h01C;
    localparam logic [11:0] IO_OKI_BANK = 12'h030;

    // vdp register offsets, low nibble of the byte address
    localparam logic [3:0] VDP_PTR    = 4'h0;
    localparam logic [3:0] VDP_RAM_H  = 4'h4;
    localparam logic [3:0] VDP_RAM_L  = 4'h6;
    localparam logic [3:0] VDP_SELECT = 4'h8;
    localparam logic [3:0] VDP_REG    = 4'hC;

endpackage
